//--- tb.f
+incdir+include
verilog/hist_pkg.sv
verilog/event_decode.sv
verilog/hist_accumulate.sv
verilog/hist_readout.sv
verilog/hist_top.sv
verif/tb_clock.sv
verif/hist_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the histogram testbench with Verilator and runs it
# the verdict comes from the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module hist_tb -f tb.f -o hist_sim \
    && ./obj_dir/hist_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verif/hist_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_settings.svh"

module hist_tb;

    import hist_pkg::*;

    localparam int WORD_BITS = `HIST_WORD_BITS;
    localparam int ADDR_BITS = `HIST_ADDR_BITS;
    localparam int DEPTH     = 1 << ADDR_BITS;
    localparam int CREDITS   = `HIST_CREDITS;
    localparam int ACQ_NUM   = `HIST_ACQ_NUM;
    // stimulus sizes per phase
    localparam int RAND_HISTS = 4;
    localparam int ACQ_HITS   = 12;
    localparam int SAT_HITS   = 300;
    localparam int PAIR_HITS  = 20;
    localparam int OVF_HITS   = 4;
    localparam int DROP_HITS  = 10;
    localparam int STIM_WORDS = RAND_HISTS * ACQ_NUM * (ACQ_HITS + 1) + SAT_HITS + PAIR_HITS
                                + ACQ_NUM + 3 * ACQ_NUM * (OVF_HITS + 1) + DROP_HITS;
    localparam int WATCHDOG_CYCLES = STIM_WORDS * 40 + 2000;

    typedef logic [ADDR_BITS-1:0]        addr_t;
    typedef logic [`HIST_COUNT_BITS-1:0] count_t;
    localparam count_t COUNT_MAX = '1;
    // pixel 2 bin 5
    localparam addr_t  SAT_ADDR  = addr_t'(37);

    logic       clk;
    logic       res = 1'b0;
    hist_in_t   in_word = '0;
    logic       in_valid = 1'b0;
    logic       credit_return = 1'b0;
    hist_word_t out_word;
    logic       out_valid;
    logic       hist_bank;
    logic       overflow;
    logic       init_done;

    // reference histogram with one array per bank
    count_t model [0:1][0:DEPTH-1];
    logic   model_bank = 1'b0;
    int     acq_seen = 0;
    int     dumps_due = 0;
    int     words_seen = 0;
    // hits sent while a swap waits are not counted
    logic   drop_mode = 1'b0;
    logic   hold_credits = 1'b0;
    // credits the DUT holds as seen from outside
    int     tb_credits = CREDITS;

    tb_clock u_clock (.clk(clk));

    hist_top dut (
        .clk           (clk),
        .res           (res),
        .in_word       (in_word),
        .in_valid      (in_valid),
        .credit_return (credit_return),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .hist_bank     (hist_bank),
        .overflow      (overflow),
        .init_done     (init_done)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first failing check");
    endtask

    function automatic count_t saturating_inc(input count_t c);
        if (c == COUNT_MAX) begin
            return c;
        end
        return c + count_t'(1);
    endfunction

    task automatic idle_cycle();
        in_valid <= 1'b0;
        @(posedge clk);
    endtask

    // address is pixel-major then bin
    task automatic send_hit(input addr_t addr);
        hist_in_t w;
        w           = '0;
        w.hit.kind  = `HIST_KIND_HIT;
        w.hit.pixel = addr[ADDR_BITS-1:`HIST_BIN_BITS];
        w.hit.bin   = addr[`HIST_BIN_BITS-1:0];
        if (!drop_mode) begin
            model[model_bank][addr] = saturating_inc(model[model_bank][addr]);
        end
        in_word  <= w;
        in_valid <= 1'b1;
        @(posedge clk);
    endtask

    // marker with a random tag
    // every ACQ_NUM-th one closes the bank
    task automatic send_marker();
        hist_in_t w;
        w             = hist_in_t'(WORD_BITS'($urandom));
        w.marker.kind = `HIST_KIND_MARKER;
        acq_seen      = acq_seen + 1;
        if (acq_seen == ACQ_NUM) begin
            acq_seen   = 0;
            model_bank = ~model_bank;
            dumps_due  = dumps_due + 1;
        end
        in_word  <= w;
        in_valid <= 1'b1;
        @(posedge clk);
    endtask

    // bank reused only after its dump so it restarts at zero
    task automatic start_histogram();
        int a;
        for (a = 0; a < DEPTH; a++) begin
            model[model_bank][addr_t'(a)] = '0;
        end
    endtask

    task automatic run_acquisition(input int n_hits);
        int i;
        for (i = 0; i < n_hits; i++) begin
            // occasional gap in the stream
            if ($urandom_range(3, 0) == 0) begin
                idle_cycle();
            end
            send_hit(addr_t'($urandom));
        end
        send_marker();
    endtask

    task automatic run_histogram(input int n_hits);
        start_histogram();
        repeat (ACQ_NUM) begin
            run_acquisition(n_hits);
        end
    endtask

    task automatic wait_for_bank(input logic exp, input int limit);
        int n;
        n = 0;
        while (hist_bank != exp && n < limit) begin
            idle_cycle();
            n++;
        end
        assert (hist_bank == exp) else
            stop_with_failure($sformatf("error hist_bank expected %h actual %h", exp, hist_bank));
    endtask

    task automatic wait_for_dumps();
        while (words_seen < dumps_due * DEPTH) begin
            idle_cycle();
        end
    endtask

    // consumer hands credits back after random delays
    always @(posedge clk or negedge res) begin : consumer
        int owed;
        int return_delay;
        if (!res) begin
            credit_return <= 1'b0;
            owed         = 0;
            return_delay = 0;
        end else begin
            credit_return <= 1'b0;
            if (out_valid) begin
                owed = owed + 1;
            end
            if (owed > 0 && !hold_credits) begin
                if (return_delay == 0) begin
                    credit_return <= 1'b1;
                    owed         = owed - 1;
                    return_delay = $urandom_range(3, 0);
                end else begin
                    return_delay = return_delay - 1;
                end
            end
        end
    end

    always @(posedge clk or negedge res) begin
        if (!res) begin
            tb_credits <= CREDITS;
        end else begin
            tb_credits <= tb_credits - (out_valid ? 1 : 0) + (credit_return ? 1 : 0);
        end
    end

    // dumps alternate banks from 0 with entries in address order
    always @(negedge clk) begin : monitor
        addr_t exp_addr;
        logic  exp_bank;
        if (res && out_valid) begin
            exp_addr = addr_t'(words_seen % DEPTH);
            exp_bank = ((words_seen / DEPTH) % 2) != 0;
            assert (out_word.bank == exp_bank) else stop_with_failure(
                $sformatf("error out_word.bank expected %h actual %h", exp_bank, out_word.bank));
            assert ({out_word.pixel, out_word.bin} == exp_addr) else stop_with_failure(
                $sformatf("error out_word.addr expected %h actual %h", exp_addr,
                          {out_word.pixel, out_word.bin}));
            assert (out_word.count == model[exp_bank][exp_addr]) else stop_with_failure(
                $sformatf("error out_word.count expected %h actual %h",
                          model[exp_bank][exp_addr], out_word.count));
            words_seen = words_seen + 1;
        end
    end

    a_credit_available: assert property (
        @(posedge clk) disable iff (!res)
        out_valid |-> (tb_credits > 0)
    ) else stop_with_failure("out_valid was raised while the DUT held no credit");

    a_overflow_sticky: assert property (
        @(posedge clk) disable iff (!res)
        !$fell(overflow)
    ) else stop_with_failure("overflow fell without a reset");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure($sformatf("timeout after %0d cycles, the run did not finish",
                                    WATCHDOG_CYCLES));
    end

    initial begin
        int init_cycles;
        void'($urandom(22));
        // reset held for two cycles
        repeat (2) @(posedge clk);
        res <= 1'b1;
        @(negedge clk);
        assert (out_valid == 1'b0) else
            stop_with_failure($sformatf("error out_valid expected %h actual %h", 1'b0, out_valid));
        assert (overflow == 1'b0) else
            stop_with_failure($sformatf("error overflow expected %h actual %h", 1'b0, overflow));
        assert (hist_bank == 1'b0) else
            stop_with_failure($sformatf("error hist_bank expected %h actual %h", 1'b0, hist_bank));
        @(posedge clk);
        // clear sweep of both banks takes one cycle per address
        init_cycles = 0;
        while (!init_done) begin
            idle_cycle();
            init_cycles++;
        end
        assert (init_cycles == DEPTH) else stop_with_failure(
            $sformatf("error init_done cycles expected %h actual %h", DEPTH, init_cycles));

        // random hits and markers with one full dump per histogram
        repeat (RAND_HISTS) begin
            run_histogram(ACQ_HITS);
            wait_for_bank(model_bank, 8);
            wait_for_dumps();
        end

        // one bin driven past the counter range then back to back pairs
        start_histogram();
        repeat (SAT_HITS) begin
            send_hit(SAT_ADDR);
        end
        for (int i = 0; i < PAIR_HITS; i++) begin
            send_hit(addr_t'(i / 2));
        end
        repeat (ACQ_NUM) begin
            send_marker();
        end
        wait_for_bank(model_bank, 8);
        wait_for_dumps();

        // next bank closes while readout of the last one is stalled
        hold_credits <= 1'b1;
        run_histogram(OVF_HITS);
        wait_for_bank(model_bank, 8);
        run_histogram(OVF_HITS);
        drop_mode = 1'b1;
        repeat (DROP_HITS) begin
            send_hit(addr_t'($urandom));
        end
        drop_mode = 1'b0;
        idle_cycle();
        idle_cycle();
        assert (overflow == 1'b1) else
            stop_with_failure($sformatf("error overflow expected %h actual %h", 1'b1, overflow));
        // swap still pending
        assert (hist_bank == ~model_bank) else stop_with_failure(
            $sformatf("error hist_bank expected %h actual %h", ~model_bank, hist_bank));
        hold_credits <= 1'b0;
        wait_for_bank(model_bank, 8 * DEPTH);
        wait_for_dumps();
        run_histogram(OVF_HITS);
        wait_for_bank(model_bank, 8);
        wait_for_dumps();

        // drain and make sure no stray words follow
        repeat (20) idle_cycle();
        assert (words_seen == dumps_due * DEPTH) else stop_with_failure(
            $sformatf("error words_seen expected %h actual %h", dumps_due * DEPTH, words_seen));
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // half of the 10 ns period
    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- verilog/hist_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_settings.svh"

module hist_top (
    input  wire                    clk,
    input  wire                    res,
    input  wire hist_pkg::hist_in_t in_word,
    input  wire                    in_valid,
    input  wire                    credit_return,
    output hist_pkg::hist_word_t   out_word,
    output logic                   out_valid,
    output logic                   hist_bank,
    output logic                   overflow,
    output logic                   init_done
);

    import hist_pkg::*;

    // decoded event, one cycle behind the input
    hist_event_t                 evt;
    // bank handover
    logic                        done_pulse;
    logic                        done_bank;
    logic                        busy;
    // read and clear port into the idle bank
    logic                        rd_en;
    logic [`HIST_ADDR_BITS-1:0]  rd_addr;
    logic [`HIST_COUNT_BITS-1:0] rd_count;

    event_decode u_decode (
        .clk      (clk),
        .res      (res),
        .in_word  (in_word),
        .in_valid (in_valid),
        .evt      (evt)
    );

    hist_accumulate u_accumulate (
        .clk        (clk),
        .res        (res),
        .evt        (evt),
        .busy       (busy),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_count   (rd_count),
        .done_pulse (done_pulse),
        .done_bank  (done_bank),
        .hist_bank  (hist_bank),
        .overflow   (overflow),
        .init_done  (init_done)
    );

    hist_readout u_readout (
        .clk           (clk),
        .res           (res),
        .done_pulse    (done_pulse),
        .done_bank     (done_bank),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_count      (rd_count),
        .busy          (busy),
        .credit_return (credit_return),
        .out_word      (out_word),
        .out_valid     (out_valid)
    );

endmodule

`default_nettype wire

//--- verilog/hist_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_settings.svh"

module hist_readout (
    input  wire                          clk,
    input  wire                          res,
    input  wire                          done_pulse,
    input  wire                          done_bank,
    output logic                         rd_en,
    output logic [`HIST_ADDR_BITS-1:0]   rd_addr,
    input  wire [`HIST_COUNT_BITS-1:0]   rd_count,
    output logic                         busy,
    input  wire                          credit_return,
    output hist_pkg::hist_word_t         out_word,
    output logic                         out_valid
);

    import hist_pkg::*;

    localparam int CREDIT_BITS = $clog2(`HIST_CREDITS + 1);
    localparam logic [`HIST_ADDR_BITS-1:0] ADDR_LAST = '1;

    logic [CREDIT_BITS-1:0]     credit_cnt;
    // address of the word now in the output register
    logic [`HIST_ADDR_BITS-1:0] addr_q;
    // bank being dumped
    logic                       bank_q;
    logic                       credit_ok;

    // the word already in flight spends a credit next cycle
    assign credit_ok = (credit_cnt > CREDIT_BITS'(out_valid));
    assign rd_en     = busy && credit_ok;

    // spend on out_valid, refill on credit_return
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            credit_cnt <= CREDIT_BITS'(`HIST_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CREDIT_BITS'(out_valid)
                          + CREDIT_BITS'(credit_return);
        end
    end

    // dump sequencer, one address per granted cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy    <= 1'b0;
            rd_addr <= '0;
            bank_q  <= 1'b0;
        end else if (done_pulse) begin
            busy    <= 1'b1;
            rd_addr <= '0;
            bank_q  <= done_bank;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
            // last entry issued, bank is free for the next swap
            if (rd_addr == ADDR_LAST) begin
                busy <= 1'b0;
            end
        end
    end

    // output valid lines up with the memory latency
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            addr_q <= rd_addr;
        end
    end

    // stamp bank, pixel and bin onto the returned count
    always_comb begin
        out_word.bank  = bank_q;
        out_word.pixel = addr_q[`HIST_ADDR_BITS-1:`HIST_BIN_BITS];
        out_word.bin   = addr_q[`HIST_BIN_BITS-1:0];
        out_word.count = rd_count;
    end

    // no word goes out without a credit
    a_credit_held: assert property (
        @(posedge clk) disable iff (!res)
        out_valid |-> (credit_cnt != '0)
    );

    // accumulator only hands over a bank while the dump is idle
    a_done_when_idle: assert property (
        @(posedge clk) disable iff (!res)
        done_pulse |-> !busy
    );

endmodule

`default_nettype wire

//--- verilog/hist_accumulate.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_settings.svh"

module hist_accumulate (
    input  wire                          clk,
    input  wire                          res,
    input  wire hist_pkg::hist_event_t   evt,
    input  wire                          busy,
    input  wire                          rd_en,
    input  wire [`HIST_ADDR_BITS-1:0]    rd_addr,
    output logic [`HIST_COUNT_BITS-1:0]  rd_count,
    output logic                         done_pulse,
    output logic                         done_bank,
    output logic                         hist_bank,
    output logic                         overflow,
    output logic                         init_done
);

    import hist_pkg::*;

    localparam int DEPTH = 1 << `HIST_ADDR_BITS;
    localparam int ACQ_BITS = $clog2(`HIST_ACQ_NUM + 1);
    localparam logic [ACQ_BITS-1:0] ACQ_LAST = ACQ_BITS'(`HIST_ACQ_NUM - 1);
    localparam logic [`HIST_ADDR_BITS-1:0] ADDR_LAST = '1;
    localparam logic [`HIST_COUNT_BITS-1:0] COUNT_MAX = '1;

    // two banks, index 0/1 then pixel-major address
    logic [`HIST_COUNT_BITS-1:0] mem [0:1][0:DEPTH-1];

    logic [`HIST_ADDR_BITS-1:0]  init_addr;
    logic [`HIST_ADDR_BITS-1:0]  ev_addr;
    logic                        ev_hit;
    logic                        ev_marker;
    logic [`HIST_COUNT_BITS-1:0] base_count;
    logic [`HIST_COUNT_BITS-1:0] next_count;
    // write stage of the read-modify-write
    logic                        wr_valid;
    logic                        wr_bank;
    logic [`HIST_ADDR_BITS-1:0]  wr_addr;
    logic [`HIST_COUNT_BITS-1:0] wr_count;
    logic [ACQ_BITS-1:0]         acq_cnt;
    logic                        swap_wait;
    logic                        swap_req;
    logic                        rd_bank;

    // readout always owns the idle bank
    assign rd_bank   = ~hist_bank;
    assign ev_addr   = {evt.pixel, evt.bin};
    assign ev_marker = init_done && evt.valid && evt.is_marker;
    // hits are lost while a finished bank waits for the swap
    assign ev_hit    = init_done && evt.valid && !evt.is_marker && !swap_wait;
    assign swap_req  = swap_wait || (ev_marker && (acq_cnt == ACQ_LAST));

    // read stage, forward the write still in flight
    always_comb begin
        if (wr_valid && (wr_bank == hist_bank) && (wr_addr == ev_addr)) begin
            base_count = wr_count;
        end else begin
            base_count = mem[hist_bank][ev_addr];
        end
        // saturate, never wrap
        next_count = (base_count == COUNT_MAX) ? base_count : base_count + 1'b1;
    end

    // clear sweep over both banks after reset
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_addr <= init_addr + 1'b1;
            if (init_addr == ADDR_LAST) begin
                init_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= ev_hit;
        end
    end

    // bank is latched so a swap cannot redirect a pending write
    always_ff @(posedge clk) begin
        if (ev_hit) begin
            wr_addr  <= ev_addr;
            wr_bank  <= hist_bank;
            wr_count <= next_count;
        end
    end

    // memory writes: sweep, increment, clear on read
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[0][init_addr] <= '0;
            mem[1][init_addr] <= '0;
        end else begin
            if (wr_valid) begin
                mem[wr_bank][wr_addr] <= wr_count;
            end
            if (rd_en) begin
                mem[rd_bank][rd_addr] <= '0;
            end
        end
    end

    // readout port, old value returned one cycle later
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_count <= mem[rd_bank][rd_addr];
        end
    end

    // marker count, bank swap, overflow flag
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acq_cnt    <= '0;
            swap_wait  <= 1'b0;
            done_pulse <= 1'b0;
            done_bank  <= 1'b0;
            hist_bank  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            done_pulse <= 1'b0;
            // markers keep counting even while the swap waits
            if (ev_marker) begin
                if (acq_cnt == ACQ_LAST) begin
                    acq_cnt <= '0;
                end else begin
                    acq_cnt <= acq_cnt + 1'b1;
                end
            end
            // swap only once the idle bank is fully drained
            if (swap_req && !busy && !done_pulse) begin
                hist_bank  <= ~hist_bank;
                done_bank  <= hist_bank;
                done_pulse <= 1'b1;
                swap_wait  <= 1'b0;
            end else if (swap_req) begin
                swap_wait <= 1'b1;
            end
            // sticky until reset
            if (init_done && evt.valid && !evt.is_marker && swap_wait) begin
                overflow <= 1'b1;
            end
        end
    end

    // increments must never land in the bank readout is clearing
    a_no_write_read_bank: assert property (
        @(posedge clk) disable iff (!res)
        (wr_valid && rd_en) |-> (wr_bank != rd_bank)
    );

    // finish strobe is a single cycle
    a_done_one_cycle: assert property (
        @(posedge clk) disable iff (!res)
        done_pulse |=> !done_pulse
    );

endmodule

`default_nettype wire

//--- verilog/event_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "hist_settings.svh"

module event_decode (
    input  wire                   clk,
    input  wire                   res,
    input  wire hist_pkg::hist_in_t in_word,
    input  wire                   in_valid,
    output hist_pkg::hist_event_t evt
);

    import hist_pkg::*;

    // captured input word, payload only
    hist_in_t word_q;
    // qualifier of word_q
    logic     valid_q;
    // kind bit of the captured word
    logic     is_marker;

    // valid pipe, cleared on reset
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // word only loads with a valid strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            word_q <= in_word;
        end
    end

    // pick the view from the kind bit
    always_comb begin
        is_marker     = (word_q.marker.kind == `HIST_KIND_MARKER);
        evt.valid     = valid_q;
        evt.is_marker = is_marker;
        if (is_marker) begin
            // markers carry no address
            evt.pixel = '0;
            evt.bin   = '0;
        end else begin
            evt.pixel = word_q.hit.pixel;
            evt.bin   = word_q.hit.bin;
        end
    end

    // front end must leave the spare field of a hit clear
    a_hit_spare_zero: assert property (
        @(posedge clk) disable iff (!res)
        (valid_q && !is_marker) |-> (word_q.hit.spare == '0)
    );

endmodule

`default_nettype wire

//--- verilog/hist_pkg.sv
`default_nettype none

`include "hist_settings.svh"

package hist_pkg;

    // hit view: kind, spare, pixel, bin
    typedef struct packed {
        logic                        kind;
        logic [`HIST_SPARE_BITS-1:0] spare;
        logic [`HIST_PIX_BITS-1:0]   pixel;
        logic [`HIST_BIN_BITS-1:0]   bin;
    } hist_hit_view_t;

    // marker view: kind plus acquisition tag
    typedef struct packed {
        logic                      kind;
        logic [`HIST_TAG_BITS-1:0] tag;
    } hist_marker_view_t;

    // one 16 bit word, read as hit or marker by its kind bit
    typedef union packed {
        hist_hit_view_t    hit;
        hist_marker_view_t marker;
    } hist_in_t;

    // decoded event handed to the accumulator
    typedef struct packed {
        logic                      valid;
        logic                      is_marker;
        logic [`HIST_PIX_BITS-1:0] pixel;
        logic [`HIST_BIN_BITS-1:0] bin;
    } hist_event_t;

    // one histogram entry on the output stream
    typedef struct packed {
        logic                        bank;
        logic [`HIST_PIX_BITS-1:0]   pixel;
        logic [`HIST_BIN_BITS-1:0]   bin;
        logic [`HIST_COUNT_BITS-1:0] count;
    } hist_word_t;

endpackage

`default_nettype wire

//--- include/hist_settings.svh
`ifndef HIST_SETTINGS_SVH
`define HIST_SETTINGS_SVH

// raw detector word width
`define HIST_WORD_BITS 16

// kind bit encoding, msb of every input word
`define HIST_KIND_HIT 1'b0
`define HIST_KIND_MARKER 1'b1

// histogram geometry, 16 bins by 4 pixels
`define HIST_BIN_BITS 4
`define HIST_PIX_BITS 2
`define HIST_ADDR_BITS (`HIST_PIX_BITS + `HIST_BIN_BITS)

// saturating bin counter
`define HIST_COUNT_BITS 8

// markers that close one histogram
`define HIST_ACQ_NUM 4

// output credits held after reset
`define HIST_CREDITS 4

// unused tail of a hit word, and the marker tag field
`define HIST_SPARE_BITS (`HIST_WORD_BITS - 1 - `HIST_PIX_BITS - `HIST_BIN_BITS)
`define HIST_TAG_BITS (`HIST_WORD_BITS - 1)

`endif
